// ==== design/credit_counter.sv ====
/* Downstream credit tracker. The count starts full and the issue queue must
   never return more credits than it was given */

`include "rename_defs.svh"

module credit_counter (
	input  logic clk,
	input  logic rst,
	input  logic rsp_sent,
	input  logic credit_return,
	output logic have_credit,
	output logic last_credit
);
	localparam int CNT_W = $clog2(`RN_CREDITS + 1);

	// Free slots in the issue queue
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= CNT_W'(`RN_CREDITS);
		end else begin
			// A send and a return in the same cycle cancel out
			case ({rsp_sent, credit_return})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign have_credit = (count != '0);

	// A send now would leave nothing unless a credit is coming back this cycle
	assign last_credit = (count == CNT_W'(1)) && !credit_return;

	// The sequencer only sends while holding a credit
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		rsp_sent && !credit_return |-> count != '0)
		else $error("credit_counter sent with no credit left");

	// The issue queue never hands back a slot it did not receive
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		credit_return && !rsp_sent |-> count < CNT_W'(`RN_CREDITS))
		else $error("credit_counter returned beyond the reset count");

endmodule

// ==== design/rename_ctrl_pkg.sv ====
/* Control encodings for the renamer. Only two opcode classes are modelled,
   so the opcode carries no more than whether a destination is written */

package rename_ctrl_pkg;

	// ==============================
	// Opcode classes
	// ==============================

	// op_write allocates a new destination tag and updates the map
	// op_nowrite only looks up its sources
	typedef enum logic [1:0] {
		op_nowrite = 2'd0,
		op_write   = 2'd1
	} rename_op_e;

	// ==============================
	// Sequencer states
	// ==============================

	// st_init holds off traffic for one cycle after reset
	// st_stall waits for the issue queue to hand back a credit
	typedef enum logic [1:0] {
		st_init  = 2'd0,
		st_run   = 2'd1,
		st_stall = 2'd2
	} rename_state_e;

endpackage

// ==== design/rename_fsm.sv ====
/* Rename sequencer. One request per cycle, response one cycle after accept.
   Banks are taken round robin, which needs RN_BANKS to be a power of two */

`include "rename_defs.svh"

module rename_fsm (
	input  logic                          clk,
	input  logic                          rst,
	input  rename_types_pkg::rename_req_t req,
	output logic                          ready,
	output rename_types_pkg::rename_rsp_t rsp,
	output rename_types_pkg::arch_reg_t   rd_a,
	output rename_types_pkg::arch_reg_t   rd_b,
	output rename_types_pkg::arch_reg_t   rd_d,
	input  rename_types_pkg::phys_tag_t   tag_a,
	input  rename_types_pkg::phys_tag_t   tag_b,
	input  rename_types_pkg::phys_tag_t   tag_d,
	input  logic                          mapped_a,
	input  logic                          mapped_b,
	input  logic                          mapped_d,
	output logic                          wr_en,
	output rename_types_pkg::arch_reg_t   wr_reg,
	output rename_types_pkg::phys_tag_t   wr_tag,
	input  rename_types_pkg::phys_tag_t   heads [`RN_BANKS],
	output logic [`RN_BANKS-1:0]          rot_en,
	output logic                          rsp_sent,
	input  logic                          have_credit,
	input  logic                          last_credit
);
	import rename_types_pkg::*;
	import rename_ctrl_pkg::*;

	localparam int BANKS = `RN_BANKS;

	rename_state_e state;
	rename_state_e state_nxt;
	bank_idx_t bank_ptr;
	logic accept;
	logic is_write;
	phys_tag_t head_sel;

	// ==============================
	// Handshake and steering
	// ==============================

	// Run state implies at least one credit is held
	assign ready    = (state == st_run);
	assign accept   = req.valid && ready;
	assign is_write = (req.op == op_write);
	assign head_sel = heads[bank_ptr];

	// Map lookups come straight from the held request
	assign rd_a = req.src_a;
	assign rd_b = req.src_b;
	assign rd_d = req.dst;

	// Writing instructions claim the pointed bank's head tag
	assign wr_en  = accept && is_write;
	assign wr_reg = req.dst;
	assign wr_tag = head_sel;
	assign rot_en = wr_en ? (BANKS'(1) << bank_ptr) : '0;

	// The credit is taken at accept, ahead of the registered response
	assign rsp_sent = accept;

	always_comb begin
		state_nxt = state;
		case (state)
			st_init:  state_nxt = st_run;
			st_run:   if (accept && last_credit) state_nxt = st_stall;
			st_stall: if (have_credit) state_nxt = st_run;
			default:  state_nxt = st_init;
		endcase
	end

	// ==============================
	// State and response register
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_init;
			bank_ptr  <= '0;
			rsp.valid <= 1'b0;
		end else begin
			state     <= state_nxt;
			rsp.valid <= accept;
			// Pointer wraps naturally at the bank count
			if (wr_en) begin
				bank_ptr <= bank_ptr + 1'b1;
			end
			if (accept) begin
				rsp.op         <= req.op;
				rsp.new_tag    <= is_write ? head_sel : '0;
				// Old destination is reported for both opcode classes
				rsp.old_tag    <= tag_d;
				rsp.old_mapped <= mapped_d;
				rsp.tag_a      <= tag_a;
				rsp.mapped_a   <= mapped_a;
				rsp.tag_b      <= tag_b;
				rsp.mapped_b   <= mapped_b;
			end
		end
	end

	// Only one bank may give up a tag per cycle, and it must be the bank the tag came from
	a_rot_onehot: assert property (@(posedge clk)
		$onehot0(rot_en) && (!wr_en || rot_en[wr_tag.bank]))
		else $error("rename_fsm rot_en %b does not match the tag bank", rot_en);

endmodule

// ==== design/rename_map_table.sv ====
/* Architectural to physical map with three read ports and one write port.
   Reads are combinational and return the pre-write value in a write cycle */

`include "rename_defs.svh"

module rename_map_table (
	input  logic                        clk,
	input  logic                        rst,
	input  rename_types_pkg::arch_reg_t rd_a,
	input  rename_types_pkg::arch_reg_t rd_b,
	input  rename_types_pkg::arch_reg_t rd_d,
	output rename_types_pkg::phys_tag_t tag_a,
	output rename_types_pkg::phys_tag_t tag_b,
	output rename_types_pkg::phys_tag_t tag_d,
	output logic                        mapped_a,
	output logic                        mapped_b,
	output logic                        mapped_d,
	input  logic                        wr_en,
	input  rename_types_pkg::arch_reg_t wr_reg,
	input  rename_types_pkg::phys_tag_t wr_tag
);
	import rename_types_pkg::*;

	localparam int REGS = `RN_ARCH_REGS;

	// Current physical tag per architectural register
	phys_tag_t map_tag [REGS];

	// Set once a register has been given a tag since reset
	logic [REGS-1:0] map_valid;

	// ==============================
	// Write port
	// ==============================

	// Tag storage. A stale tag is harmless while its mapped bit is low
	always_ff @(posedge clk) begin
		if (wr_en) begin
			map_tag[wr_reg] <= wr_tag;
		end
	end

	// Mapped bits start clear so no entry aliases a tag still in a ring
	always_ff @(posedge clk) begin
		if (rst) begin
			map_valid <= '0;
		end else if (wr_en) begin
			map_valid[wr_reg] <= 1'b1;
		end
	end

	// ==============================
	// Read ports
	// ==============================

	// Sources for the request being renamed
	assign tag_a    = map_tag[rd_a];
	assign mapped_a = map_valid[rd_a];
	assign tag_b    = map_tag[rd_b];
	assign mapped_b = map_valid[rd_b];

	// Destination lookup yields the tag being displaced
	assign tag_d    = map_tag[rd_d];
	assign mapped_d = map_valid[rd_d];

endmodule

// ==== design/rename_types_pkg.sv ====
/* Data types shared by the renamer and its neighbours. The tag layout is
   bank over ring index, so widths follow the sizing macros directly */

`include "rename_defs.svh"

package rename_types_pkg;

	// Architectural register index
	typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_reg_t;

	// Bank number and index within one bank's ring
	typedef logic [$clog2(`RN_BANKS)-1:0] bank_idx_t;
	typedef logic [$clog2(`RN_RING_DEPTH)-1:0] ring_idx_t;

	// Physical tag, 8 bits with the default sizing
	typedef struct packed {
		bank_idx_t bank;
		ring_idx_t idx;
	} phys_tag_t;

	// Rename request from the front end, held until accepted
	typedef struct packed {
		logic                        valid;
		rename_ctrl_pkg::rename_op_e op;
		arch_reg_t                   dst;
		arch_reg_t                   src_a;
		arch_reg_t                   src_b;
	} rename_req_t;

	// Response to the issue queue
	// The mapped bits are low where a register has never been written since reset
	typedef struct packed {
		logic                        valid;
		rename_ctrl_pkg::rename_op_e op;
		phys_tag_t                   new_tag;
		phys_tag_t                   old_tag;
		logic                        old_mapped;
		phys_tag_t                   tag_a;
		logic                        mapped_a;
		phys_tag_t                   tag_b;
		logic                        mapped_b;
	} rename_rsp_t;

endpackage

// ==== design/renamer_top.sv ====
/* Single-wide register renamer. Tags recycle by ring rotation only, so
   in-order retirement with fewer than 256 tags in flight is assumed */

`include "rename_defs.svh"

module renamer_top (
	input  logic                          clk,
	input  logic                          rst,
	input  rename_types_pkg::rename_req_t req,
	output logic                          ready,
	output rename_types_pkg::rename_rsp_t rsp,
	input  logic                          credit_return
);
	import rename_types_pkg::*;

	// Map table lookups and update
	arch_reg_t rd_a;
	arch_reg_t rd_b;
	arch_reg_t rd_d;
	phys_tag_t tag_a;
	phys_tag_t tag_b;
	phys_tag_t tag_d;
	logic mapped_a;
	logic mapped_b;
	logic mapped_d;
	logic wr_en;
	arch_reg_t wr_reg;
	phys_tag_t wr_tag;

	// Free-tag banks
	phys_tag_t heads [`RN_BANKS];
	logic [`RN_BANKS-1:0] rot_en;

	// Credit handshake
	logic rsp_sent;
	logic have_credit;
	logic last_credit;

	rename_fsm i_fsm (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.ready       (ready),
		.rsp         (rsp),
		.rd_a        (rd_a),
		.rd_b        (rd_b),
		.rd_d        (rd_d),
		.tag_a       (tag_a),
		.tag_b       (tag_b),
		.tag_d       (tag_d),
		.mapped_a    (mapped_a),
		.mapped_b    (mapped_b),
		.mapped_d    (mapped_d),
		.wr_en       (wr_en),
		.wr_reg      (wr_reg),
		.wr_tag      (wr_tag),
		.heads       (heads),
		.rot_en      (rot_en),
		.rsp_sent    (rsp_sent),
		.have_credit (have_credit),
		.last_credit (last_credit)
	);

	credit_counter i_credit (
		.clk           (clk),
		.rst           (rst),
		.rsp_sent      (rsp_sent),
		.credit_return (credit_return),
		.have_credit   (have_credit),
		.last_credit   (last_credit)
	);

	rename_map_table i_map (
		.clk      (clk),
		.rst      (rst),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.rd_d     (rd_d),
		.tag_a    (tag_a),
		.tag_b    (tag_b),
		.tag_d    (tag_d),
		.mapped_a (mapped_a),
		.mapped_b (mapped_b),
		.mapped_d (mapped_d),
		.wr_en    (wr_en),
		.wr_reg   (wr_reg),
		.wr_tag   (wr_tag)
	);

	// One ring per bank, bank number baked into each head tag
	for (genvar b = 0; b < `RN_BANKS; b++) begin : g_bank
		tag_rotator #(
			.bank_id (b)
		) i_rot (
			.clk  (clk),
			.rst  (rst),
			.rot  (rot_en[b]),
			.head (heads[b])
		);
	end

endmodule

// ==== design/tag_rotator.sv ====
/* One bank's free-tag ring. Tags are never returned; the ring simply wraps,
   so reuse is safe only while fewer than the full tag space is in flight */

`include "rename_defs.svh"

module tag_rotator #(
	parameter int bank_id = 0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        rot,
	output rename_types_pkg::phys_tag_t head
);
	import rename_types_pkg::*;

	localparam int DEPTH = `RN_RING_DEPTH;

	// Ring of indices, entry 0 is the next tag handed out
	ring_idx_t ring [DEPTH];

	// ==============================
	// Ring storage
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			// Identity load, so the bank yields 0,1,2,... after reset
			for (int i = 0; i < DEPTH; i++) begin
				ring[i] <= ring_idx_t'(i);
			end
		end else if (rot) begin
			// Shift toward the head and wrap the consumed index to the tail
			for (int i = 0; i < DEPTH - 1; i++) begin
				ring[i] <= ring[i+1];
			end
			ring[DEPTH-1] <= ring[0];
		end
	end

	// Head tag carries this bank's number in its upper bits
	assign head = '{bank: bank_idx_t'(bank_id), idx: ring[0]};

	// ==============================
	// Checks
	// ==============================

	// The sequencer must not consume a tag while the ring is being reloaded
	a_no_rot_in_reset: assert property (@(posedge clk) rst |-> !rot)
		else $error("tag_rotator %0d rotated during reset", bank_id);

endmodule

// ==== include/rename_defs.svh ====
/* Sizing for the renamer slice. RN_BANKS and RN_RING_DEPTH must be powers of two,
   since the tag is the bank number over the ring index with no spare codes */

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ==============================
// Architectural state
// ==============================

// Number of architectural registers seen by the front end
`define RN_ARCH_REGS 32

// ==============================
// Physical tag space
// ==============================

// Free-tag banks. The bank number forms the upper tag bits
`define RN_BANKS 4

// Tags held in each bank's ring, which sets the lower tag bits
`define RN_RING_DEPTH 64

// Downstream issue queue slots free at reset
`define RN_CREDITS 4

`endif

// ==== tb/renamer_tb.sv ====
/* Self-checking testbench for the renamer. Checks run as concurrent assertions
   against a cycle model, and the first mismatch stops the run */

`include "rename_defs.svh"

module renamer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import rename_types_pkg::*;
	import rename_ctrl_pkg::*;

	localparam int REQ_COUNT   = 2000;
	localparam int STALL_AT    = 1000;
	localparam int WAIT_LIMIT  = 200;
	localparam int HOLD_CYCLES = 24;

	logic        clk;
	logic        rst;
	rename_req_t req;
	logic        ready;
	rename_rsp_t rsp;
	logic        credit_return;

	// Model state, all updated on the rising edge
	rename_state_e m_state;
	logic          m_ready;
	logic          m_accept;
	int            m_credits;
	int            m_k;
	phys_tag_t     m_map [`RN_ARCH_REGS];
	logic [`RN_ARCH_REGS-1:0] m_mapped;
	rename_rsp_t   exp_rsp;

	// Responses delivered to the issue queue and not yet handed back
	int in_flight;

	// Low until the first edge, so X values before reset are not checked
	logic armed;

	// Credit returns are held off while set
	logic withhold;

	int error_count;

	renamer_top i_dut (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.ready         (ready),
		.rsp           (rsp),
		.credit_return (credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// Reference model
	// ==============================

	// Tag order is banks 0,1,2,3 in turn, each ring counting up from 0
	function automatic phys_tag_t alloc_tag(input int k);
		phys_tag_t t;
		t.bank = bank_idx_t'(k % `RN_BANKS);
		t.idx  = ring_idx_t'((k / `RN_BANKS) % `RN_RING_DEPTH);
		return t;
	endfunction

	assign m_ready  = (m_state == st_run);
	assign m_accept = req.valid && m_ready;

	always @(posedge clk) begin
		armed <= 1'b1;
		if (rst) begin
			m_state   <= st_init;
			m_credits <= `RN_CREDITS;
			m_k       <= 0;
			m_mapped  <= '0;
			exp_rsp   <= '0;
			in_flight <= 0;
		end else begin
			in_flight     <= in_flight + int'(rsp.valid) - int'(credit_return);
			m_credits     <= m_credits - int'(m_accept) + int'(credit_return);
			exp_rsp.valid <= m_accept;
			// One init cycle, then stall on the last credit until one comes back
			case (m_state)
				st_init:  m_state <= st_run;
				st_run:   if (m_accept && m_credits == 1 && !credit_return) m_state <= st_stall;
				st_stall: if (m_credits != 0) m_state <= st_run;
				default:  m_state <= st_init;
			endcase
			if (m_accept) begin
				exp_rsp.op         <= req.op;
				exp_rsp.new_tag    <= alloc_tag(m_k);
				exp_rsp.old_tag    <= m_map[req.dst];
				exp_rsp.old_mapped <= m_mapped[req.dst];
				exp_rsp.tag_a      <= m_map[req.src_a];
				exp_rsp.mapped_a   <= m_mapped[req.src_a];
				exp_rsp.tag_b      <= m_map[req.src_b];
				exp_rsp.mapped_b   <= m_mapped[req.src_b];
				// The next lookup sees this write
				if (req.op == op_write) begin
					m_map[req.dst]    <= alloc_tag(m_k);
					m_mapped[req.dst] <= 1'b1;
					m_k               <= m_k + 1;
				end
			end
		end
	end

	// ==============================
	// Checks
	// ==============================

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count++;
		$display("Fail at %0.1f ns: %s expected %0h, got %0h", $realtime, name, expected,
			actual);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	// Covers reset, the init cycle, stall entry and resume
	a_ready: assert property (@(posedge clk) armed |-> ready == m_ready)
		else report_mismatch("ready", $sampled(m_ready), $sampled(ready));

	// Exactly one response per accept, one cycle later
	a_rsp_valid: assert property (@(posedge clk) armed |-> rsp.valid == exp_rsp.valid)
		else report_mismatch("rsp.valid", $sampled(exp_rsp.valid), $sampled(rsp.valid));

	a_rsp_op: assert property (@(posedge clk) armed && exp_rsp.valid |-> rsp.op == exp_rsp.op)
		else report_mismatch("rsp.op", $sampled(exp_rsp.op), $sampled(rsp.op));

	a_new_tag: assert property (@(posedge clk)
		armed && exp_rsp.valid && exp_rsp.op == op_write |-> rsp.new_tag == exp_rsp.new_tag)
		else report_mismatch("rsp.new_tag", $sampled(exp_rsp.new_tag), $sampled(rsp.new_tag));

	a_old_mapped: assert property (@(posedge clk)
		armed && exp_rsp.valid |-> rsp.old_mapped == exp_rsp.old_mapped)
		else report_mismatch("rsp.old_mapped", $sampled(exp_rsp.old_mapped),
			$sampled(rsp.old_mapped));

	// Tags are only meaningful where the register has been mapped
	a_old_tag: assert property (@(posedge clk)
		armed && exp_rsp.valid && exp_rsp.old_mapped |-> rsp.old_tag == exp_rsp.old_tag)
		else report_mismatch("rsp.old_tag", $sampled(exp_rsp.old_tag), $sampled(rsp.old_tag));

	a_mapped_a: assert property (@(posedge clk)
		armed && exp_rsp.valid |-> rsp.mapped_a == exp_rsp.mapped_a)
		else report_mismatch("rsp.mapped_a", $sampled(exp_rsp.mapped_a), $sampled(rsp.mapped_a));

	a_tag_a: assert property (@(posedge clk)
		armed && exp_rsp.valid && exp_rsp.mapped_a |-> rsp.tag_a == exp_rsp.tag_a)
		else report_mismatch("rsp.tag_a", $sampled(exp_rsp.tag_a), $sampled(rsp.tag_a));

	a_mapped_b: assert property (@(posedge clk)
		armed && exp_rsp.valid |-> rsp.mapped_b == exp_rsp.mapped_b)
		else report_mismatch("rsp.mapped_b", $sampled(exp_rsp.mapped_b), $sampled(rsp.mapped_b));

	a_tag_b: assert property (@(posedge clk)
		armed && exp_rsp.valid && exp_rsp.mapped_b |-> rsp.tag_b == exp_rsp.tag_b)
		else report_mismatch("rsp.tag_b", $sampled(exp_rsp.tag_b), $sampled(rsp.tag_b));

	// The issue queue never holds more responses than it has slots
	a_in_flight: assert property (@(posedge clk) armed |-> in_flight <= `RN_CREDITS)
		else report_mismatch("in_flight", `RN_CREDITS, $sampled(in_flight));

	// ==============================
	// Stimulus
	// ==============================

	// Half the time source a reads the previous destination, to hit the bypass case
	function automatic rename_req_t random_req(input arch_reg_t last_dst);
		rename_req_t r;
		r.valid = 1'b1;
		r.op    = ($urandom_range(3) != 0) ? op_write : op_nowrite;
		r.dst   = arch_reg_t'($urandom_range(15));
		r.src_a = ($urandom_range(1) != 0) ? last_dst :
			arch_reg_t'($urandom_range(`RN_ARCH_REGS - 1));
		r.src_b = arch_reg_t'($urandom_range(`RN_ARCH_REGS - 1));
		return r;
	endfunction

	// Called on a falling edge, returns on the falling edge after the accept
	task automatic issue(input rename_req_t r);
		int waited;
		waited = 0;
		req = r;
		while (!ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!ready) begin
			$display("Timeout: ready stayed low for %0d cycles at %0.1f ns", waited, $realtime);
			$display("=== FAIL ===");
			$fatal(1, "Request was never accepted");
		end else begin
			@(negedge clk);
			req.valid = 1'b0;
		end
	endtask

	// Let the issue queue hand back every slot before the stall test
	task automatic drain_credits();
		int waited;
		waited = 0;
		while (m_credits != `RN_CREDITS && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (m_credits != `RN_CREDITS) begin
			$display("Timeout: issue queue slots never drained at %0.1f ns", $realtime);
			$display("=== FAIL ===");
			$fatal(1, "Credits did not return");
		end else begin
			@(negedge clk);
		end
	endtask

	initial begin
		rename_req_t r;
		arch_reg_t   last_dst;
		int          sent;
		void'($urandom(17957));
		armed         = 1'b0;
		withhold      = 1'b0;
		error_count   = 0;
		req           = '0;
		credit_return = 1'b0;
		rst           = 1'b1;
		last_dst      = '0;
		sent          = 0;

		// Issue queue frees a slot at random, never more than it holds
		fork
			forever begin
				@(negedge clk);
				credit_return = !withhold && in_flight > 0 && $urandom_range(3) != 0;
			end
		join_none

		repeat (5) @(negedge clk);
		rst = 1'b0;

		while (sent < REQ_COUNT) begin
			if (sent == STALL_AT) begin
				drain_credits();
				@(posedge clk);
				withhold = 1'b1;
				@(negedge clk);
				// Two requests past the credit count, the last must wait for a return
				fork
					begin
						for (int i = 0; i < `RN_CREDITS + 2; i++) begin
							r = random_req(last_dst);
							issue(r);
							last_dst = r.dst;
						end
					end
					begin
						repeat (HOLD_CYCLES) @(posedge clk);
						withhold = 1'b0;
					end
				join
				sent += `RN_CREDITS + 2;
			end else begin
				r = random_req(last_dst);
				issue(r);
				last_dst = r.dst;
				sent++;
			end
		end

		// Last response lands one cycle after its accept
		repeat (2) @(negedge clk);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
design/rename_ctrl_pkg.sv
design/rename_types_pkg.sv
design/tag_rotator.sv
design/rename_map_table.sv
design/credit_counter.sv
design/rename_fsm.sv
design/renamer_top.sv
tb/renamer_tb.sv
